// File: design/arcade_io_pkg.sv
/* Arcade input and board configuration definitions */
package arcade_io_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [10:0] ps2_key_t;
	typedef logic [15:0] joy_word_t;
	typedef logic [4:0]  player_ctl_t;
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0]  board_id_t;

	// Board numbers as sent in the board select byte
	localparam board_id_t BOARD_SPACE_INVADERS = 8'd0;
	localparam board_id_t BOARD_VORTEX         = 8'd2;
	localparam board_id_t BOARD_BOOT_HILL      = 8'd5;
	localparam board_id_t BOARD_AMAZING_MAZE   = 8'd14;

	// Download port indexes
	localparam byte_t DL_INDEX_BOARD = 8'd1;
	localparam byte_t DL_INDEX_DIP   = 8'd254;
	localparam int    NUM_DIP_BYTES  = 3;

	// ps2_key fields
	localparam int PS2_TOGGLE_BIT = 10;
	localparam int PS2_PRESS_BIT  = 9;

	// Player control bits, same layout as the joystick low bits
	localparam int CTL_RIGHT = 0;
	localparam int CTL_LEFT  = 1;
	localparam int CTL_DOWN  = 2;
	localparam int CTL_UP    = 3;
	localparam int CTL_FIRE  = 4;

	// Shared joystick buttons
	localparam int JOY_START1 = 8;
	localparam int JOY_START2 = 9;
	localparam int JOY_COIN   = 10;

	////////////////////////////////////////////////////////////
	// Scan codes
	////////////////////////////////////////////////////////////
	localparam logic [8:0] KEY_P1_UP    = 9'h075;
	localparam logic [8:0] KEY_P1_DOWN  = 9'h072;
	localparam logic [8:0] KEY_P1_LEFT  = 9'h06B;
	localparam logic [8:0] KEY_P1_RIGHT = 9'h074;
	localparam logic [8:0] KEY_P1_FIRE  = 9'h014;
	localparam logic [8:0] KEY_P2_UP    = 9'h02D;
	localparam logic [8:0] KEY_P2_DOWN  = 9'h02B;
	localparam logic [8:0] KEY_P2_LEFT  = 9'h023;
	localparam logic [8:0] KEY_P2_RIGHT = 9'h034;
	localparam logic [8:0] KEY_P2_FIRE  = 9'h01C;
	localparam logic [8:0] KEY_F1       = 9'h005;
	localparam logic [8:0] KEY_1        = 9'h016;
	localparam logic [8:0] KEY_F2       = 9'h006;
	localparam logic [8:0] KEY_2        = 9'h01E;
	localparam logic [8:0] KEY_ESC      = 9'h076;
	localparam logic [8:0] KEY_5        = 9'h02E;
	localparam logic [8:0] KEY_6        = 9'h036;

	// Default port_wr bit per trigger, Space Invaders layout
	localparam int TRIG_DEF_SHIFT_COUNT = 2;
	localparam int TRIG_DEF_AUDIO_P1    = 3;
	localparam int TRIG_DEF_SHIFT_DATA  = 4;
	localparam int TRIG_DEF_AUDIO_P2    = 5;
	localparam int TRIG_DEF_WATCHDOG    = 6;

endpackage

// File: design/arcade_io_top.sv
/* Arcade control input top level */
`timescale 1ns/10ps

module arcade_io_top
	import arcade_io_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  ps2_key_t  ps2_key,
	input  joy_word_t joy1,
	input  joy_word_t joy2,
	input  logic      dl_wr,
	input  byte_t     dl_index,
	input  dl_addr_t  dl_addr,
	input  byte_t     dl_data,
	input  byte_t     port_wr,
	input  byte_t     shifter_data,
	output byte_t     gdb0,
	output byte_t     gdb1,
	output byte_t     gdb2,
	output byte_t     gdb3,
	output logic      trig_shift_count,
	output logic      trig_shift_data,
	output logic      trig_audio_p1,
	output logic      trig_audio_p2,
	output logic      trig_watchdog,
	output logic      wd_enabled,
	output logic      landscape,
	output logic      rotate_ccw
);

	player_ctl_t p1;
	player_ctl_t p2;
	logic        start1;
	logic        start2;
	logic        coin;
	board_id_t   board_sel;
	byte_t       dip0;
	byte_t       dip1;
	byte_t       dip2;

	player_input_decoder u_decoder (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ps2_key (ps2_key),
		.joy1    (joy1),
		.joy2    (joy2),
		.p1      (p1),
		.p2      (p2),
		.start1  (start1),
		.start2  (start2),
		.coin    (coin)
	);

	board_config_store u_store (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.dl_wr     (dl_wr),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.board_sel (board_sel),
		.dip0      (dip0),
		.dip1      (dip1),
		.dip2      (dip2)
	);

	input_port_mapper u_mapper (
		.p1               (p1),
		.p2               (p2),
		.start1           (start1),
		.start2           (start2),
		.coin             (coin),
		.board_sel        (board_sel),
		.dip0             (dip0),
		.dip1             (dip1),
		.dip2             (dip2),
		.port_wr          (port_wr),
		.shifter_data     (shifter_data),
		.gdb0             (gdb0),
		.gdb1             (gdb1),
		.gdb2             (gdb2),
		.gdb3             (gdb3),
		.trig_shift_count (trig_shift_count),
		.trig_shift_data  (trig_shift_data),
		.trig_audio_p1    (trig_audio_p1),
		.trig_audio_p2    (trig_audio_p2),
		.trig_watchdog    (trig_watchdog),
		.wd_enabled       (wd_enabled),
		.landscape        (landscape),
		.rotate_ccw       (rotate_ccw)
	);

endmodule

// File: design/board_config_store.sv
/* Board select and DIP switch store */
`timescale 1ns/10ps

module board_config_store
	import arcade_io_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      dl_wr,
	input  byte_t     dl_index,
	input  dl_addr_t  dl_addr,
	input  byte_t     dl_data,
	output board_id_t board_sel,
	output byte_t     dip0,
	output byte_t     dip1,
	output byte_t     dip2
);

	localparam int DIP_SEL_W = $clog2(NUM_DIP_BYTES);

	logic                 board_wr;
	logic                 dip_wr;
	logic [DIP_SEL_W-1:0] dip_sel;
	board_id_t            board_q;
	byte_t                dip_q [NUM_DIP_BYTES];

	// Write decode
	assign board_wr = dl_wr && (dl_index == DL_INDEX_BOARD);
	assign dip_wr   = dl_wr && (dl_index == DL_INDEX_DIP)
		&& (dl_addr < dl_addr_t'(NUM_DIP_BYTES));
	assign dip_sel  = dl_addr[DIP_SEL_W-1:0];

	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			board_q <= BOARD_SPACE_INVADERS;
			for (int i = 0; i < NUM_DIP_BYTES; i++)
				dip_q[i] <= '0;
		end
		else
		begin
			if (board_wr)
				board_q <= dl_data;
			if (dip_wr)
				dip_q[dip_sel] <= dl_data;
		end
	end

	assign board_sel = board_q;
	assign dip0      = dip_q[0];
	assign dip1      = dip_q[1];
	assign dip2      = dip_q[2];

endmodule

// File: design/input_port_mapper.sv
/* Per-board input port mapper */
`timescale 1ns/10ps

module input_port_mapper
	import arcade_io_pkg::*;
(
	input  player_ctl_t p1,
	input  player_ctl_t p2,
	input  logic        start1,
	input  logic        start2,
	input  logic        coin,
	input  board_id_t   board_sel,
	input  byte_t       dip0,
	input  byte_t       dip1,
	input  byte_t       dip2,
	input  byte_t       port_wr,
	input  byte_t       shifter_data,
	output byte_t       gdb0,
	output byte_t       gdb1,
	output byte_t       gdb2,
	output byte_t       gdb3,
	output logic        trig_shift_count,
	output logic        trig_shift_data,
	output logic        trig_audio_p1,
	output logic        trig_audio_p2,
	output logic        trig_watchdog,
	output logic        wd_enabled,
	output logic        landscape,
	output logic        rotate_ccw
);

	logic m_right;
	logic m_left;
	logic m_fire;

	// Either player drives the shared cabinet controls
	assign m_right = p1[CTL_RIGHT] | p2[CTL_RIGHT];
	assign m_left  = p1[CTL_LEFT] | p2[CTL_LEFT];
	assign m_fire  = p1[CTL_FIRE] | p2[CTL_FIRE];

	always_comb
	begin
		////////////////////////////////////////////////////////////
		// Defaults, also used by unknown boards
		////////////////////////////////////////////////////////////
		gdb0             = 8'hFF;
		gdb1             = 8'hFF;
		gdb2             = 8'hFF;
		gdb3             = shifter_data;
		landscape        = 1'b1;
		rotate_ccw       = 1'b0;
		wd_enabled       = 1'b1;
		trig_shift_count = port_wr[TRIG_DEF_SHIFT_COUNT];
		trig_audio_p1    = port_wr[TRIG_DEF_AUDIO_P1];
		trig_shift_data  = port_wr[TRIG_DEF_SHIFT_DATA];
		trig_audio_p2    = port_wr[TRIG_DEF_AUDIO_P2];
		trig_watchdog    = port_wr[TRIG_DEF_WATCHDOG];

		case (board_sel)
			BOARD_SPACE_INVADERS:
			begin
				// Upright cabinet, monitor turned
				landscape  = 1'b0;
				rotate_ccw = 1'b1;
				gdb0 = dip0 | {1'b1, m_right, m_left, m_fire, 1'b1, 1'b1, 1'b1, 1'b1};
				gdb1 = dip1 | {1'b1, m_right, m_left, m_fire, 1'b1, start1, start2, coin};
				gdb2 = dip2 | {1'b1, m_right, m_left, m_fire, 1'b0, 1'b0, 1'b1, 1'b1};
			end
			BOARD_VORTEX:
			begin
				landscape  = 1'b0;
				rotate_ccw = 1'b1;
				// Shifter moves to port 1, players split over ports 2 and 3
				gdb0 = 8'hFF;
				gdb1 = shifter_data;
				gdb2 = dip1 | {1'b1, p1[CTL_RIGHT], p1[CTL_LEFT], p1[CTL_FIRE],
					1'b1, start1, start2, coin};
				gdb3 = dip2 | {1'b0, p2[CTL_RIGHT], p2[CTL_LEFT], p2[CTL_FIRE],
					4'b0000};
				trig_shift_count = port_wr[0];
				trig_audio_p1    = port_wr[1];
				trig_shift_data  = port_wr[6];
				trig_audio_p2    = port_wr[7];
				trig_watchdog    = port_wr[4];
			end
			BOARD_BOOT_HILL:
			begin
				// One byte per gunslinger
				gdb0 = dip0 | {p1[CTL_FIRE], 1'b0, 1'b1, 1'b0,
					p1[CTL_RIGHT], p1[CTL_LEFT], p1[CTL_DOWN], p1[CTL_UP]};
				gdb1 = dip1 | {p2[CTL_FIRE], 1'b0, 1'b1, 1'b0,
					p2[CTL_RIGHT], p2[CTL_LEFT], p2[CTL_DOWN], p2[CTL_UP]};
				gdb2 = dip2 | {start1, coin, start1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1};
				trig_shift_count = port_wr[1];
				trig_audio_p1    = port_wr[3];
				trig_shift_data  = port_wr[2];
				trig_audio_p2    = port_wr[5];
				trig_watchdog    = port_wr[4];
			end
			BOARD_AMAZING_MAZE:
			begin
				// No watchdog on this board
				wd_enabled = 1'b0;
				gdb0 = dip0 | {p2[CTL_UP], p2[CTL_DOWN], p2[CTL_RIGHT], p2[CTL_LEFT],
					p1[CTL_UP], p1[CTL_DOWN], p1[CTL_RIGHT], p1[CTL_LEFT]};
				gdb1 = dip1 | {4'b0000, coin, 1'b0, start2, start1};
				gdb2 = 8'h00;
			end
			default:
			begin
			end
		endcase
	end

endmodule

// File: design/player_input_decoder.sv
/* Key and joystick decoder */
`timescale 1ns/10ps

module player_input_decoder
	import arcade_io_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n,
	input  ps2_key_t    ps2_key,
	input  joy_word_t   joy1,
	input  joy_word_t   joy2,
	output player_ctl_t p1,
	output player_ctl_t p2,
	output logic        start1,
	output logic        start2,
	output logic        coin
);

	logic        toggle_q;
	logic        key_event;
	logic        key_pressed;
	logic [8:0]  key_code;
	player_ctl_t key_p1;
	player_ctl_t key_p2;
	logic        key_start1;
	logic        key_start2;
	logic        key_coin_a;
	logic        key_coin_b;
	joy_word_t   joy_any;

	assign key_event   = ps2_key[PS2_TOGGLE_BIT] != toggle_q;
	assign key_pressed = ps2_key[PS2_PRESS_BIT];
	assign key_code    = ps2_key[8:0];

	// Toggle history, follows the host every cycle
	always_ff @(posedge clk_sys)
	begin
		toggle_q <= ps2_key[PS2_TOGGLE_BIT];
	end

	////////////////////////////////////////////////////////////
	// Held key states
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk_sys)
	begin
		if (!rst_n)
		begin
			key_p1     <= '0;
			key_p2     <= '0;
			key_start1 <= 1'b0;
			key_start2 <= 1'b0;
			key_coin_a <= 1'b0;
			key_coin_b <= 1'b0;
		end
		else if (key_event)
		begin
			case (key_code)
				KEY_P1_UP:    key_p1[CTL_UP]    <= key_pressed;
				KEY_P1_DOWN:  key_p1[CTL_DOWN]  <= key_pressed;
				KEY_P1_LEFT:  key_p1[CTL_LEFT]  <= key_pressed;
				KEY_P1_RIGHT: key_p1[CTL_RIGHT] <= key_pressed;
				KEY_P1_FIRE:  key_p1[CTL_FIRE]  <= key_pressed;
				KEY_P2_UP:    key_p2[CTL_UP]    <= key_pressed;
				KEY_P2_DOWN:  key_p2[CTL_DOWN]  <= key_pressed;
				KEY_P2_LEFT:  key_p2[CTL_LEFT]  <= key_pressed;
				KEY_P2_RIGHT: key_p2[CTL_RIGHT] <= key_pressed;
				KEY_P2_FIRE:  key_p2[CTL_FIRE]  <= key_pressed;
				// Function keys and MAME style keys share a state
				KEY_F1,
				KEY_1:        key_start1 <= key_pressed;
				KEY_F2,
				KEY_2:        key_start2 <= key_pressed;
				KEY_ESC,
				KEY_5:        key_coin_a <= key_pressed;
				KEY_6:        key_coin_b <= key_pressed;
				default:      ;
			endcase
		end
	end

	// Joystick merge, no added delay
	assign joy_any = joy1 | joy2;

	assign p1 = key_p1 | joy1[$bits(player_ctl_t)-1:0];
	assign p2 = key_p2 | joy2[$bits(player_ctl_t)-1:0];

	assign start1 = key_start1 | joy_any[JOY_START1];
	assign start2 = key_start2 | joy_any[JOY_START2];
	assign coin   = key_coin_a | key_coin_b | joy_any[JOY_COIN];

endmodule

// File: files.f
design/arcade_io_pkg.sv
design/player_input_decoder.sv
design/board_config_store.sv
design/input_port_mapper.sv
design/arcade_io_top.sv
tb/arcade_io_assert.sv
tb/tb_arcade_io.sv

// File: tb/arcade_io_assert.sv
/* Arcade top level port assertions */
`timescale 1ns/10ps

module arcade_io_assert
	import arcade_io_pkg::*;
(
	input logic  clk_sys,
	input logic  rst_n,
	input byte_t port_wr,
	input logic  trig_shift_count,
	input logic  trig_shift_data,
	input logic  trig_audio_p1,
	input logic  trig_audio_p2,
	input logic  trig_watchdog,
	input logic  landscape,
	input logic  rotate_ccw
);

	logic [4:0] trigs;
	int         fail_count = 0;

	assign trigs = {trig_watchdog, trig_audio_p2, trig_shift_data, trig_audio_p1,
		trig_shift_count};

	// Triggers are strobes routed straight from port_wr
	a_idle_triggers: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(port_wr == 8'h00) |-> (trigs == 5'b00000))
		else
		begin
			$error("trigger active while port_wr is zero");
			fail_count++;
		end

	a_orientation: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(landscape && rotate_ccw))
		else
		begin
			$error("landscape and rotate_ccw both high");
			fail_count++;
		end

	generate
		for (genvar i = 0; i < 5; i++)
		begin : g_trig
			a_trig_from_port: assert property (@(posedge clk_sys) disable iff (!rst_n)
				trigs[i] ? (|port_wr) : !(&port_wr))
				else
				begin
					$error("trigger %0d equals no bit of port_wr", i);
					fail_count++;
				end
		end
	endgenerate

endmodule

bind arcade_io_top arcade_io_assert u_assert (.*);

// File: tb/tb_arcade_io.sv
/* Arcade input testbench */
`timescale 1ns/10ps

module tb_arcade_io
	import arcade_io_pkg::*;
();

	logic        clk_sys;
	logic        rst_n;
	ps2_key_t    ps2_key;
	joy_word_t   joy1;
	joy_word_t   joy2;
	logic        dl_wr;
	byte_t       dl_index;
	dl_addr_t    dl_addr;
	byte_t       dl_data;
	byte_t       port_wr;
	byte_t       shifter_data;
	byte_t       gdb0;
	byte_t       gdb1;
	byte_t       gdb2;
	byte_t       gdb3;
	logic        trig_shift_count;
	logic        trig_shift_data;
	logic        trig_audio_p1;
	logic        trig_audio_p2;
	logic        trig_watchdog;
	logic        wd_enabled;
	logic        landscape;
	logic        rotate_ccw;

	// Reference state as applied by the tests
	player_ctl_t kp1;
	player_ctl_t kp2;
	logic [3:0]  kmisc;   // start 1, start 2, coin A, coin B
	board_id_t   m_board;
	byte_t       m_dip [3];
	int          errors;
	int          test_errs;
	int          tests_run;
	int          tests_failed;
	int          rnd;

	arcade_io_top dut0 (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever
			#5 clk_sys = ~clk_sys;
	end

	initial
	begin
		#200000;
		$display("Timeout: the run did not complete within 200 us");
		$display("Test failures found");
		$finish;
	end

	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic compare(input string tname, input string field, input logic [7:0] exp_v,
		input logic [7:0] act_v);
		if (act_v !== exp_v)
		begin
			$display("MISMATCH %s %s expected %h actual %h", tname, field, exp_v, act_v);
			errors++;
			test_errs++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Trigger bit positions, watchdog field down to shift count field
	function automatic logic [14:0] route(input board_id_t b);
		case (b)
			8'd2:    return {3'd4, 3'd7, 3'd6, 3'd1, 3'd0};
			8'd5:    return {3'd4, 3'd5, 3'd2, 3'd3, 3'd1};
			default: return {3'd6, 3'd5, 3'd4, 3'd3, 3'd2};
		endcase
	endfunction

	// Right at index 0 up to fire at index 4
	function automatic logic [8:0] ctl_code(input int who, input int b);
		case (b)
			0:       return (who == 1) ? 9'h074 : 9'h034;
			1:       return (who == 1) ? 9'h06B : 9'h023;
			2:       return (who == 1) ? 9'h072 : 9'h02B;
			3:       return (who == 1) ? 9'h075 : 9'h02D;
			default: return (who == 1) ? 9'h014 : 9'h01C;
		endcase
	endfunction

	function automatic board_id_t board_at(input int i);
		case (i)
			0:       return 8'd0;
			1:       return 8'd2;
			2:       return 8'd5;
			3:       return 8'd14;
			default: return 8'd9;
		endcase
	endfunction

	task automatic check_outputs(input string tname);
		player_ctl_t a;
		player_ctl_t b;
		logic        s1;
		logic        s2;
		logic        c;
		logic        r;
		logic        l;
		logic        f;
		byte_t       e [4];
		logic [2:0]  e_flags;
		logic [4:0]  e_trig;
		logic [14:0] rt;
		@(negedge clk_sys);
		a  = kp1 | joy1[4:0];
		b  = kp2 | joy2[4:0];
		s1 = kmisc[0] | joy1[8] | joy2[8];
		s2 = kmisc[1] | joy1[9] | joy2[9];
		c  = kmisc[2] | kmisc[3] | joy1[10] | joy2[10];
		r  = a[0] | b[0];
		l  = a[1] | b[1];
		f  = a[4] | b[4];
		e[0] = 8'hFF;
		e[1] = 8'hFF;
		e[2] = 8'hFF;
		e[3] = shifter_data;
		// wd_enabled, landscape, rotate_ccw
		e_flags = 3'b110;
		case (m_board)
			8'd0:
			begin
				e[0] = m_dip[0] | {1'b1, r, l, f, 4'b1111};
				e[1] = m_dip[1] | {1'b1, r, l, f, 1'b1, s1, s2, c};
				e[2] = m_dip[2] | {1'b1, r, l, f, 4'b0011};
				e_flags = 3'b101;
			end
			8'd2:
			begin
				e[1] = shifter_data;
				e[2] = m_dip[1] | {1'b1, a[0], a[1], a[4], 1'b1, s1, s2, c};
				e[3] = m_dip[2] | {1'b0, b[0], b[1], b[4], 4'b0000};
				e_flags = 3'b101;
			end
			8'd5:
			begin
				e[0] = m_dip[0] | {a[4], 3'b010, a[0], a[1], a[2], a[3]};
				e[1] = m_dip[1] | {b[4], 3'b010, b[0], b[1], b[2], b[3]};
				e[2] = m_dip[2] | {s1, c, s1, 5'b01101};
			end
			8'd14:
			begin
				e[0] = m_dip[0] | {b[3], b[2], b[0], b[1], a[3], a[2], a[0], a[1]};
				e[1] = m_dip[1] | {4'b0000, c, 1'b0, s2, s1};
				e[2] = 8'h00;
				e_flags = 3'b010;
			end
			default:
			begin
			end
		endcase
		rt = route(m_board);
		for (int i = 0; i < 5; i++)
			e_trig[i] = port_wr[rt[3*i +: 3]];
		compare(tname, "gdb0", e[0], gdb0);
		compare(tname, "gdb1", e[1], gdb1);
		compare(tname, "gdb2", e[2], gdb2);
		compare(tname, "gdb3", e[3], gdb3);
		compare(tname, "triggers", {3'b000, e_trig}, {3'b000, trig_watchdog, trig_audio_p2,
			trig_shift_data, trig_audio_p1, trig_shift_count});
		compare(tname, "flags", {5'b00000, e_flags}, {5'b00000, wd_enabled, landscape,
			rotate_ccw});
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////

	// who 1 and 2 address a player bit, anything else a start or coin bit
	task automatic key(input logic [8:0] code, input int who, input int bit_idx,
		input logic pressed);
		step();
		ps2_key = {~ps2_key[10], pressed, code};
		if (who == 1)
			kp1[bit_idx] = pressed;
		else if (who == 2)
			kp2[bit_idx] = pressed;
		else
			kmisc[bit_idx] = pressed;
		// Key state taken on the next edge, checked after the one that follows
		step();
		step();
	endtask

	task automatic dl_write(input byte_t index, input dl_addr_t addr, input byte_t data);
		step();
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		if (index == 8'd1)
			m_board = data;
		else if (index == 8'd254 && addr < 3)
			m_dip[addr[1:0]] = data;
		step();
		dl_wr = 1'b0;
	endtask

	task automatic end_test(input string tname);
		tests_run++;
		if (test_errs == 0)
			$display("test %-18s ok", tname);
		else
		begin
			$display("test %-18s %0d errors", tname, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////
	task automatic reset_defaults();
		check_outputs("reset_defaults");
		step();
		port_wr = 8'h7C;
		check_outputs("reset_defaults");
		step();
		port_wr = 8'h00;
		end_test("reset_defaults");
	endtask

	task automatic vortex_keys();
		dl_write(8'd1, '0, 8'd2);
		for (int who = 1; who <= 2; who++)
			for (int b = 0; b < 5; b++)
			begin
				key(ctl_code(who, b), who, b, 1'b1);
				check_outputs("vortex_keys");
				key(ctl_code(who, b), who, b, 1'b0);
				check_outputs("vortex_keys");
			end
		end_test("vortex_keys");
	endtask

	task automatic dip_writes();
		for (int a = 0; a < 3; a++)
			dl_write(8'd254, dl_addr_t'(a), byte_t'($urandom));
		// Out of range and wrong index writes must leave the bytes alone
		dl_write(8'd254, dl_addr_t'(3), byte_t'($urandom));
		dl_write(8'd254, dl_addr_t'(8), byte_t'($urandom));
		dl_write(8'd253, '0, 8'hFF);
		for (int i = 0; i < 4; i++)
		begin
			dl_write(8'd1, '0, board_at(i));
			check_outputs("dip_writes");
		end
		// Open switches so later tests see every control bit
		for (int a = 0; a < 3; a++)
			dl_write(8'd254, dl_addr_t'(a), 8'h00);
		end_test("dip_writes");
	endtask

	task automatic joystick_merge();
		dl_write(8'd1, '0, 8'd0);
		step();
		joy1 = 16'h0001;
		joy2 = 16'h0110;
		check_outputs("joystick_merge");
		key(9'h074, 1, 0, 1'b1);
		step();
		joy1 = '0;
		check_outputs("joystick_merge");
		key(9'h074, 1, 0, 1'b0);
		step();
		joy2 = 16'h0400;
		check_outputs("joystick_merge");
		step();
		joy2 = '0;
		key(9'h076, 0, 2, 1'b1);
		check_outputs("joystick_merge");
		key(9'h076, 0, 2, 1'b0);
		key(9'h02E, 0, 2, 1'b1);
		check_outputs("joystick_merge");
		key(9'h02E, 0, 2, 1'b0);
		key(9'h036, 0, 3, 1'b1);
		check_outputs("joystick_merge");
		key(9'h036, 0, 3, 1'b0);
		key(9'h005, 0, 0, 1'b1);
		key(9'h01E, 0, 1, 1'b1);
		check_outputs("joystick_merge");
		key(9'h005, 0, 0, 1'b0);
		key(9'h01E, 0, 1, 1'b0);
		dl_write(8'd1, '0, 8'd5);
		joy2 = 16'h001C;
		check_outputs("joystick_merge");
		step();
		joy2 = '0;
		end_test("joystick_merge");
	endtask

	task automatic trigger_routing();
		for (int i = 0; i < 5; i++)
		begin
			dl_write(8'd1, '0, board_at(i));
			for (int k = 0; k < 12; k++)
			begin
				step();
				port_wr = (k < 8) ? byte_t'(1 << k) : byte_t'($urandom);
				check_outputs("trigger_routing");
			end
		end
		step();
		port_wr = 8'h00;
		end_test("trigger_routing");
	endtask

	task automatic maze_and_unknown();
		dl_write(8'd1, '0, 8'd14);
		key(9'h075, 1, 3, 1'b1);
		key(9'h023, 2, 1, 1'b1);
		check_outputs("maze_and_unknown");
		key(9'h075, 1, 3, 1'b0);
		key(9'h023, 2, 1, 1'b0);
		joy1 = 16'h0005;
		joy2 = 16'h000A;
		check_outputs("maze_and_unknown");
		step();
		joy1 = '0;
		joy2 = '0;
		dl_write(8'd1, '0, 8'd77);
		shifter_data = byte_t'($urandom);
		check_outputs("maze_and_unknown");
		end_test("maze_and_unknown");
	endtask

	initial
	begin
		rnd          = $urandom(32'hf439e5ab);
		errors       = 0;
		test_errs    = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst_n        = 1'b0;
		ps2_key      = '0;
		joy1         = '0;
		joy2         = '0;
		dl_wr        = 1'b0;
		dl_index     = '0;
		dl_addr      = '0;
		dl_data      = '0;
		port_wr      = '0;
		shifter_data = 8'h5A;
		kp1          = '0;
		kp2          = '0;
		kmisc        = '0;
		m_board      = 8'd0;
		for (int i = 0; i < 3; i++)
			m_dip[i] = '0;
		repeat (5) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		reset_defaults();
		vortex_keys();
		dip_writes();
		joystick_merge();
		trigger_routing();
		maze_and_unknown();
		if (dut0.u_assert.fail_count != 0)
		begin
			$display("%0d assertion failures in the bound checker",
				dut0.u_assert.fail_count);
			errors += dut0.u_assert.fail_count;
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
